// ==== sim.f ====
rtl/chip_cfg_pkg.sv
rtl/chip_mem_pkg.sv
rtl/tag_master.sv
rtl/tag_client_bank.sv
rtl/mem_cmd_switch.sv
rtl/credit_link_tx.sv
rtl/chip_top.sv
dv/chip_properties.sv
dv/chip_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module chip_tb -f sim.f -o chip_tb_sim

run: compile
	./obj_dir/chip_tb_sim | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/chip_tb.sv ====
module chip_tb
  import chip_cfg_pkg::*;
  import chip_mem_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int TAG_PKT_W  = 1 + TAG_ID_W + TAG_PAYLOAD_W;
  // idle zeros, bits with gaps, write latency
  localparam int TAG_MAX_CYCLES  = 3 + TAG_PKT_W * 5 + 2;
  localparam int DIRECTED_TAGS   = 10;
  localparam int DIRECTED_CYCLES = 300;
  localparam int RAND_ITERS      = 300;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + DIRECTED_TAGS * TAG_MAX_CYCLES
                                 + DIRECTED_CYCLES + RAND_ITERS * TAG_MAX_CYCLES + 500;
  localparam int DELAY_N = 64;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  tag_en_i;
  logic  tag_data_i;
  logic  cmd_v_i;
  cmd_t  cmd_data_i;
  logic  cmd_ready_o;
  logic  byp_v_o;
  logic  dmc_v_o;
  flit_t byp_flit_o;
  flit_t dmc_flit_o;
  logic  byp_credit_i = 1'b0;
  logic  dmc_credit_i = 1'b0;

  // reference model
  int    seed;
  logic  exp_sel = 1'b0;
  logic  exp_en  = 1'b0;
  did_t  exp_did = '0;
  logic  exp_ready;
  int    byp_cr = LINK_CREDITS;
  int    dmc_cr = LINK_CREDITS;
  flit_t byp_exp_q[$];
  flit_t dmc_exp_q[$];
  int    accept_cnt = 0;
  int    byp_sent = 0;
  int    dmc_sent = 0;

  // credit return state
  int    delay_tab [DELAY_N];
  int    cycle_cnt = 0;
  int    byp_seen = 0;
  int    dmc_seen = 0;
  int    byp_ret_q[$];
  int    dmc_ret_q[$];
  logic  dmc_gate = 1'b0;
  int    dmc_allow = 0;
  int    dmc_returned = 0;

  int           r;
  int           start_cnt;
  tag_payload_t pl;

  always #20 clk_i = ~clk_i;

  chip_top uut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_en_i     (tag_en_i),
    .tag_data_i   (tag_data_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .byp_v_o      (byp_v_o),
    .dmc_v_o      (dmc_v_o),
    .byp_flit_o   (byp_flit_o),
    .dmc_flit_o   (dmc_flit_o),
    .byp_credit_i (byp_credit_i),
    .dmc_credit_i (dmc_credit_i)
  );

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_val, act_val);
    $display("Verification failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    $display("Verification failed");
    $fatal(1, "check failed");
  endtask

  ////////////////////////////////////////
  // stimulus tasks

  // one packet, msb first, with random enable gaps
  task automatic send_tag(input tag_id_t id, input tag_payload_t data);
    logic [TAG_PKT_W-1:0] bits;
    int gap;
    bits = {1'b1, id, data};
    // zeros while idle are filler
    repeat ($random(seed) & 3) begin
      tag_en_i   <= 1'b1;
      tag_data_i <= 1'b0;
      @(posedge clk_i);
    end
    for (int i = TAG_PKT_W - 1; i >= 0; i--) begin
      gap = (($random(seed) & 3) == 0) ? ($random(seed) & 3) + 1 : 0;
      repeat (gap) begin
        tag_en_i   <= 1'b0;
        tag_data_i <= 1'($random(seed));
        @(posedge clk_i);
      end
      tag_en_i   <= 1'b1;
      tag_data_i <= bits[i];
      @(posedge clk_i);
    end
    tag_en_i <= 1'b0;
    // client register loads on this edge
    @(posedge clk_i);
    if (id == tag_id_t'(CLIENT_LINK_CTRL)) begin
      exp_sel = data[LINK_SEL_BIT];
      exp_en  = data[LINK_EN_BIT];
    end else if (id == tag_id_t'(CLIENT_DST_ID)) begin
      exp_did = did_t'(data);
    end
  endtask

  task automatic run_cmds(input int n);
    for (int i = 0; i < n; i++) begin
      cmd_v_i    <= (($random(seed) & 3) != 0);
      cmd_data_i <= cmd_t'($random(seed));
      @(posedge clk_i);
    end
  endtask

  // idle until every credit is back
  task automatic wait_drain();
    cmd_v_i <= 1'b0;
    @(posedge clk_i);
    while (byp_cr != LINK_CREDITS || dmc_cr != LINK_CREDITS) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////
  // scoreboard and model update

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      byp_cr = LINK_CREDITS;
      dmc_cr = LINK_CREDITS;
    end else begin
      // flits accepted one cycle ago
      if (byp_exp_q.size() != 0) begin
        assert (byp_v_o === 1'b1) else report_mismatch("byp_v_o", 1, 32'(byp_v_o));
        assert (byp_flit_o === byp_exp_q[0])
          else report_mismatch("byp_flit_o", 32'(byp_exp_q[0]), 32'(byp_flit_o));
        void'(byp_exp_q.pop_front());
        byp_sent++;
      end else begin
        assert (byp_v_o === 1'b0) else report_mismatch("byp_v_o", 0, 32'(byp_v_o));
      end
      if (dmc_exp_q.size() != 0) begin
        assert (dmc_v_o === 1'b1) else report_mismatch("dmc_v_o", 1, 32'(dmc_v_o));
        assert (dmc_flit_o === dmc_exp_q[0])
          else report_mismatch("dmc_flit_o", 32'(dmc_exp_q[0]), 32'(dmc_flit_o));
        void'(dmc_exp_q.pop_front());
        dmc_sent++;
      end else begin
        assert (dmc_v_o === 1'b0) else report_mismatch("dmc_v_o", 0, 32'(dmc_v_o));
      end
      exp_ready = exp_en && (exp_sel ? (byp_cr != 0) : (dmc_cr != 0));
      assert (cmd_ready_o === exp_ready)
        else report_mismatch("cmd_ready_o", 32'(exp_ready), 32'(cmd_ready_o));
      // handshakes as the DUT reports them
      if (cmd_v_i && cmd_ready_o) begin
        accept_cnt++;
      end
      if (cmd_v_i && exp_ready) begin
        if (exp_sel) begin
          byp_exp_q.push_back({exp_did, cmd_data_i});
          byp_cr--;
        end else begin
          dmc_exp_q.push_back({exp_did, cmd_data_i});
          dmc_cr--;
        end
      end
      if (byp_credit_i) byp_cr++;
      if (dmc_credit_i) dmc_cr++;
    end
  end

  ////////////////////////////////////////
  // credit return model

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      byp_credit_i <= 1'b0;
      dmc_credit_i <= 1'b0;
    end else begin
      cycle_cnt++;
      if (byp_seen < byp_sent) begin
        byp_ret_q.push_back(cycle_cnt + delay_tab[byp_seen % DELAY_N]);
        byp_seen++;
      end
      if (dmc_seen < dmc_sent) begin
        dmc_ret_q.push_back(cycle_cnt + delay_tab[(dmc_seen + 17) % DELAY_N]);
        dmc_seen++;
      end
      byp_credit_i <= 1'b0;
      dmc_credit_i <= 1'b0;
      if (byp_ret_q.size() != 0 && byp_ret_q[0] <= cycle_cnt) begin
        byp_credit_i <= 1'b1;
        void'(byp_ret_q.pop_front());
      end
      if (dmc_ret_q.size() != 0 && dmc_ret_q[0] <= cycle_cnt &&
          (!dmc_gate || dmc_returned < dmc_allow)) begin
        dmc_credit_i <= 1'b1;
        void'(dmc_ret_q.pop_front());
        dmc_returned++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, traffic never drained", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // test sequence

  initial begin
    seed       = 88;
    rst_n_i    = 1'b0;
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    cmd_v_i    = 1'b0;
    cmd_data_i = '0;
    for (int i = 0; i < DELAY_N; i++) begin
      delay_tab[i] = ($random(seed) & 7) + 1;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // disabled after reset even with a request held
    cmd_v_i    <= 1'b1;
    cmd_data_i <= cmd_t'($random(seed));
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    assert (cmd_ready_o === 1'b0) else report_mismatch("cmd_ready_o", 0, 32'(cmd_ready_o));
    @(posedge clk_i);
    cmd_v_i <= 1'b0;

    // dram port first, then bypass
    send_tag(tag_id_t'(CLIENT_DST_ID), tag_payload_t'($random(seed)));
    send_tag(tag_id_t'(CLIENT_LINK_CTRL), 8'h80);
    run_cmds(20);
    send_tag(tag_id_t'(CLIENT_DST_ID), tag_payload_t'($random(seed)));
    send_tag(tag_id_t'(CLIENT_LINK_CTRL), 8'h81);
    run_cmds(20);
    wait_drain();

    // hold back dram credits
    send_tag(tag_id_t'(CLIENT_LINK_CTRL), 8'h80);
    dmc_allow  = dmc_returned;
    dmc_gate   = 1'b1;
    start_cnt  = accept_cnt;
    cmd_v_i    <= 1'b1;
    cmd_data_i <= cmd_t'($random(seed));
    repeat (LINK_CREDITS + 6) @(posedge clk_i);
    @(negedge clk_i);
    assert (accept_cnt - start_cnt == LINK_CREDITS)
      else report_mismatch("accepted commands", LINK_CREDITS, accept_cnt - start_cnt);
    dmc_allow = dmc_allow + 1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    assert (accept_cnt - start_cnt == LINK_CREDITS + 1)
      else report_mismatch("accepted commands", LINK_CREDITS + 1, accept_cnt - start_cnt);
    dmc_gate = 1'b0;
    wait_drain();

    // enable off, then writes to missing clients
    send_tag(tag_id_t'(CLIENT_LINK_CTRL), 8'h01);
    cmd_v_i <= 1'b1;
    repeat (6) @(posedge clk_i);
    cmd_v_i <= 1'b0;
    send_tag(tag_id_t'(CLIENT_LINK_CTRL), 8'h81);
    send_tag(4'd2, 8'h00);
    send_tag(4'd3, 8'h5a);
    send_tag(4'd15, 8'h00);
    run_cmds(12);
    wait_drain();

    // random traffic with occasional reprogramming
    for (int i = 0; i < RAND_ITERS; i++) begin
      r = $random(seed) & 15;
      if (r == 0) begin
        pl = tag_payload_t'($random(seed));
        pl[LINK_EN_BIT] = (($random(seed) & 7) != 0);
        send_tag(tag_id_t'(CLIENT_LINK_CTRL), pl);
      end else if (r == 1) begin
        send_tag(tag_id_t'(CLIENT_DST_ID), tag_payload_t'($random(seed)));
      end else if (r == 2) begin
        send_tag(tag_id_t'($random(seed)) | 4'h2, tag_payload_t'($random(seed)));
      end else begin
        run_cmds(8);
      end
    end
    wait_drain();
    assert (byp_exp_q.size() == 0 && dmc_exp_q.size() == 0)
      else report_failure("scoreboard still holds flits at end of run");
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== dv/chip_properties.sv ====
module chip_properties
  import chip_mem_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input credit_cnt_t credit_cnt_i,
  input logic        link_v_i
);

  ////////////////////////////////////////
  // credit link checks

  // count stays within the initial pool
  cnt_max_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_i <= CREDIT_CNT_W'(LINK_CREDITS))
    else $error("credit count above LINK_CREDITS");

  // a flit leaves only while a credit was held
  no_send_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_v_i |-> ($past(credit_cnt_i) != '0))
    else $error("link valid sent with zero credits");

  // valid clears one edge after reset is sampled
  rst_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |=> !link_v_i)
    else $error("link valid high during reset");

endmodule

bind credit_link_tx chip_properties props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .credit_cnt_i (credit_cnt_r),
  .link_v_i     (link_v_o)
);

// ==== rtl/chip_top.sv ====
module chip_top
  import chip_cfg_pkg::*;
  import chip_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  tag_en_i,
  input  logic  tag_data_i,
  input  logic  cmd_v_i,
  input  cmd_t  cmd_data_i,
  output logic  cmd_ready_o,
  output logic  byp_v_o,
  output logic  dmc_v_o,
  output flit_t byp_flit_o,
  output flit_t dmc_flit_o,
  input  logic  byp_credit_i,
  input  logic  dmc_credit_i
);

  ////////////////////////////////////////
  // tag path

  logic         client_wr;
  tag_id_t      client_id;
  tag_payload_t client_data;
  logic         link_sel;
  logic         link_en;
  did_t         dst_id;

  tag_master tag_master (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .tag_en_i      (tag_en_i),
    .tag_data_i    (tag_data_i),
    .client_wr_o   (client_wr),
    .client_id_o   (client_id),
    .client_data_o (client_data)
  );

  tag_client_bank tag_client_bank (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .client_wr_i   (client_wr),
    .client_id_i   (client_id),
    .client_data_i (client_data),
    .link_sel_o    (link_sel),
    .link_en_o     (link_en),
    .dst_id_o      (dst_id)
  );

  ////////////////////////////////////////
  // command path

  logic  byp_v;
  logic  dmc_v;
  flit_t flit;
  logic  byp_ready;
  logic  dmc_ready;

  mem_cmd_switch mem_cmd_switch (
    .cmd_v_i     (cmd_v_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .link_sel_i  (link_sel),
    .link_en_i   (link_en),
    .dst_id_i    (dst_id),
    .byp_v_o     (byp_v),
    .dmc_v_o     (dmc_v),
    .flit_o      (flit),
    .byp_ready_i (byp_ready),
    .dmc_ready_i (dmc_ready)
  );

  // bypass link
  credit_link_tx byp_link (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (byp_v),
    .flit_i      (flit),
    .ready_o     (byp_ready),
    .link_v_o    (byp_v_o),
    .link_flit_o (byp_flit_o),
    .credit_i    (byp_credit_i)
  );

  // dram controller port
  credit_link_tx dmc_link (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (dmc_v),
    .flit_i      (flit),
    .ready_o     (dmc_ready),
    .link_v_o    (dmc_v_o),
    .link_flit_o (dmc_flit_o),
    .credit_i    (dmc_credit_i)
  );

endmodule

// ==== rtl/credit_link_tx.sv ====
module credit_link_tx
  import chip_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  v_i,
  input  flit_t flit_i,
  output logic  ready_o,
  output logic  link_v_o,
  output flit_t link_flit_o,
  input  logic  credit_i
);

  credit_cnt_t credit_cnt_r;
  logic        send;

  // at least one credit held
  assign ready_o = (credit_cnt_r != '0);
  assign send    = v_i & ready_o;

  ////////////////////////////////////////
  // credit counter

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt_r <= CREDIT_CNT_W'(LINK_CREDITS);
    end else begin
      case ({send, credit_i})
        2'b10:   credit_cnt_r <= credit_cnt_r - 1'b1;
        2'b01:   credit_cnt_r <= credit_cnt_r + 1'b1;
        // send and return cancel out
        default: credit_cnt_r <= credit_cnt_r;
      endcase
    end
  end

  ////////////////////////////////////////
  // output register

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      link_v_o <= 1'b0;
    end else begin
      link_v_o <= send;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      link_flit_o <= flit_i;
    end
  end

endmodule

// ==== rtl/mem_cmd_switch.sv ====
module mem_cmd_switch
  import chip_mem_pkg::*;
(
  input  logic  cmd_v_i,
  input  cmd_t  cmd_data_i,
  output logic  cmd_ready_o,
  input  logic  link_sel_i,
  input  logic  link_en_i,
  input  did_t  dst_id_i,
  output logic  byp_v_o,
  output logic  dmc_v_o,
  output flit_t flit_o,
  input  logic  byp_ready_i,
  input  logic  dmc_ready_i
);

  logic cmd_v_en;
  logic sel_ready;

  ////////////////////////////////////////
  // flit formation

  // destination id rides above the command
  assign flit_o = {dst_id_i, cmd_data_i};

  ////////////////////////////////////////
  // static demux

  assign cmd_v_en = cmd_v_i & link_en_i;

  always_comb begin
    byp_v_o = 1'b0;
    dmc_v_o = 1'b0;
    if (link_sel_i) begin
      byp_v_o = cmd_v_en;
    end else begin
      dmc_v_o = cmd_v_en;
    end
  end

  // only the selected link can stall the source
  assign sel_ready = link_sel_i ? byp_ready_i : dmc_ready_i;

  // disabled switch refuses everything
  assign cmd_ready_o = link_en_i & sel_ready;

endmodule

// ==== rtl/tag_client_bank.sv ====
module tag_client_bank
  import chip_cfg_pkg::*;
  import chip_mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         client_wr_i,
  input  tag_id_t      client_id_i,
  input  tag_payload_t client_data_i,
  output logic         link_sel_o,
  output logic         link_en_o,
  output did_t         dst_id_o
);

  tag_payload_t client_r [TAG_NUM_CLIENTS];

  ////////////////////////////////////////
  // client registers

  // ids past the last client match nothing and are dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TAG_NUM_CLIENTS; i++) begin
        client_r[i] <= '0;
      end
    end else if (client_wr_i) begin
      for (int i = 0; i < TAG_NUM_CLIENTS; i++) begin
        if (client_id_i == tag_id_t'(i)) begin
          client_r[i] <= client_data_i;
        end
      end
    end
  end

  ////////////////////////////////////////
  // field decode

  // sel 0 picks the dram controller port
  assign link_sel_o = client_r[CLIENT_LINK_CTRL][LINK_SEL_BIT];
  assign link_en_o  = client_r[CLIENT_LINK_CTRL][LINK_EN_BIT];

  assign dst_id_o = did_t'(client_r[CLIENT_DST_ID]);

endmodule

// ==== rtl/tag_master.sv ====
module tag_master
  import chip_cfg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         tag_en_i,
  input  logic         tag_data_i,
  output logic         client_wr_o,
  output tag_id_t      client_id_o,
  output tag_payload_t client_data_o
);

  tag_state_e             state_r;
  logic [TAG_CNT_W-1:0]   bit_cnt_r;
  tag_id_t                id_r;
  tag_payload_t           payload_r;
  logic                   id_last;
  logic                   payload_last;

  assign id_last      = (bit_cnt_r == TAG_CNT_W'(TAG_ID_W - 1));
  assign payload_last = (bit_cnt_r == TAG_CNT_W'(TAG_PAYLOAD_W - 1));

  ////////////////////////////////////////
  // packet FSM

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r     <= TAG_IDLE;
      bit_cnt_r   <= '0;
      client_wr_o <= 1'b0;
    end else begin
      client_wr_o <= 1'b0;
      if (tag_en_i) begin
        case (state_r)
          TAG_IDLE: begin
            // zeros between packets are idle filler
            if (tag_data_i) begin
              state_r   <= TAG_ID;
              bit_cnt_r <= '0;
            end
          end
          TAG_ID: begin
            if (id_last) begin
              state_r   <= TAG_PAYLOAD;
              bit_cnt_r <= '0;
            end else begin
              bit_cnt_r <= bit_cnt_r + 1'b1;
            end
          end
          TAG_PAYLOAD: begin
            if (payload_last) begin
              state_r     <= TAG_IDLE;
              client_wr_o <= 1'b1;
            end else begin
              bit_cnt_r <= bit_cnt_r + 1'b1;
            end
          end
          default: begin
            state_r <= TAG_IDLE;
          end
        endcase
      end
    end
  end

  // shift in msb first
  always_ff @(posedge clk_i) begin
    if (tag_en_i && state_r == TAG_ID) begin
      id_r <= {id_r[TAG_ID_W-2:0], tag_data_i};
    end
    if (tag_en_i && state_r == TAG_PAYLOAD) begin
      payload_r <= {payload_r[TAG_PAYLOAD_W-2:0], tag_data_i};
    end
  end

  // stable while the write pulse is high
  assign client_id_o   = id_r;
  assign client_data_o = payload_r;

endmodule

// ==== rtl/chip_mem_pkg.sv ====
package chip_mem_pkg;

  ////////////////////////////////////////
  // command and flit widths

  localparam int CMD_W  = 16;
  localparam int DID_W  = 8;
  localparam int FLIT_W = DID_W + CMD_W;

  ////////////////////////////////////////
  // link credits

  localparam int LINK_CREDITS = 4;

  // must hold 0 through LINK_CREDITS
  localparam int CREDIT_CNT_W = $clog2(LINK_CREDITS + 1);

  ////////////////////////////////////////
  // types

  typedef logic [CMD_W-1:0]        cmd_t;
  typedef logic [DID_W-1:0]        did_t;
  typedef logic [FLIT_W-1:0]       flit_t;
  typedef logic [CREDIT_CNT_W-1:0] credit_cnt_t;

endpackage

// ==== rtl/chip_cfg_pkg.sv ====
package chip_cfg_pkg;

  ////////////////////////////////////////
  // tag serial protocol

  localparam int TAG_ID_W      = 4;
  localparam int TAG_PAYLOAD_W = 8;

  // bit counter covers the longer of the two fields
  localparam int TAG_CNT_W = $clog2(TAG_PAYLOAD_W);

  ////////////////////////////////////////
  // client registers

  localparam int TAG_NUM_CLIENTS = 2;

  localparam int CLIENT_LINK_CTRL = 0;
  localparam int CLIENT_DST_ID    = 1;

  // link control payload fields
  localparam int LINK_SEL_BIT = 0;
  localparam int LINK_EN_BIT  = 7;

  ////////////////////////////////////////
  // types

  typedef logic [TAG_ID_W-1:0]      tag_id_t;
  typedef logic [TAG_PAYLOAD_W-1:0] tag_payload_t;

  // master waits for start bit, then id, then payload
  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_ID,
    TAG_PAYLOAD
  } tag_state_e;

endpackage
